// File: common/mipsPkg.sv
package mipsPkg;

    // Field and word widths
    parameter int regAddrW = 5;
    parameter int dataW = 32;

    // Primary opcode field
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJ       = 6'b000010,
        opBeq     = 6'b000100,
        opOri     = 6'b001101,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opcodeE;

    // R-type function field
    typedef enum logic [5:0] {
        fnAddu = 6'b100001,
        fnSubu = 6'b100011
    } functE;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOpE;

    // Cycles until an operand is needed or a result is ready
    typedef logic [1:0] stageTimeT;

    // Tuse of a register field the instruction never reads
    parameter stageTimeT tuseIdle = 2'd3;

    // Operand source chosen by the hazard unit
    typedef enum logic [1:0] {
        fwdNone,
        fwdM,
        fwdW
    } fwdSelE;

    parameter logic [dataW-1:0] resetPc = 32'h0000_3000;

endpackage

// File: fetch/fetchStage.sv
`timescale 1ns/1ps
module fetchStage import mipsPkg::*; #(
    parameter logic [dataW-1:0] ResetPc = resetPc
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             stall,
    input  logic             branchTaken,
    input  logic [dataW-1:0] branchTarget,
    output logic [dataW-1:0] instAddr,
    input  logic [dataW-1:0] instData,
    output logic [dataW-1:0] instD,
    output logic [dataW-1:0] pcD
);

    logic [dataW-1:0] pc;

    assign instAddr = pc;

    // A stall wins over a redirect, the branch is decided again next cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
            instD <= '0;
        end else if (!stall) begin
            pc <= branchTaken ? branchTarget : pc + 32'd4;
            instD <= instData;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pc;
        end
    end

endmodule

// File: decode/decodeStage.sv
`timescale 1ns/1ps
module decodeStage import mipsPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [dataW-1:0]    instD,
    input  logic [dataW-1:0]    pcD,
    input  logic [dataW-1:0]    rsData,
    input  logic [dataW-1:0]    rtData,
    output logic [regAddrW-1:0] rsAddr,
    output logic [regAddrW-1:0] rtAddr,
    output stageTimeT           rsTuse,
    output stageTimeT           rtTuse,
    input  fwdSelE              fwdRsD,
    input  fwdSelE              fwdRtD,
    input  logic [dataW-1:0]    resultM,
    input  logic [dataW-1:0]    resultW,
    input  logic                stall,
    output logic                branchTaken,
    output logic [dataW-1:0]    branchTarget,
    output mipsPkg::aluOpE      aluOpE,
    output logic                useImmE,
    output logic [dataW-1:0]    immE,
    output logic [dataW-1:0]    rsValE,
    output logic [dataW-1:0]    rtValE,
    output logic [regAddrW-1:0] destE,
    output stageTimeT           tnewE,
    output logic                isLoadE,
    output logic                isStoreE,
    output logic [dataW-1:0]    pcE
);

    opcodeE              op;
    functE               fn;
    logic [dataW-1:0]    immZero, immSign, pcPlus4, rsVal, rtVal;
    mipsPkg::aluOpE      aluOp;
    logic                useImm, isLoad, isStore, isBeq, isJ;
    logic [dataW-1:0]    imm;
    logic [regAddrW-1:0] dest;
    stageTimeT           tnew;

    assign op = opcodeE'(instD[31:26]);
    assign fn = functE'(instD[5:0]);
    assign rsAddr = instD[25:21];
    assign rtAddr = instD[20:16];
    assign immZero = {16'b0, instD[15:0]};
    assign immSign = {{16{instD[15]}}, instD[15:0]};

    // Unknown encodings fall through as bubbles
    always_comb begin
        aluOp = aluAdd;
        useImm = 1'b0;
        imm = immZero;
        dest = '0;
        tnew = 2'd0;
        isLoad = 1'b0;
        isStore = 1'b0;
        isBeq = 1'b0;
        isJ = 1'b0;
        rsTuse = tuseIdle;
        rtTuse = tuseIdle;
        case (op)
            opSpecial: begin
                if (fn == fnAddu || fn == fnSubu) begin
                    aluOp = (fn == fnSubu) ? aluSub : aluAdd;
                    dest = instD[15:11];
                    tnew = 2'd1;
                    rsTuse = 2'd1;
                    rtTuse = 2'd1;
                end
            end
            opOri, opLui: begin
                aluOp = (op == opLui) ? aluLui : aluOr;
                useImm = 1'b1;
                dest = rtAddr;
                tnew = 2'd1;
                rsTuse = (op == opOri) ? 2'd1 : tuseIdle;
            end
            opLw: begin
                useImm = 1'b1;
                imm = immSign;
                dest = rtAddr;
                tnew = 2'd2;
                isLoad = 1'b1;
                rsTuse = 2'd1;
            end
            opSw: begin
                useImm = 1'b1;
                imm = immSign;
                isStore = 1'b1;
                rsTuse = 2'd1;
                // Store data is taken in execute, no forwarding in memory
                rtTuse = 2'd1;
            end
            opBeq: begin
                isBeq = 1'b1;
                rsTuse = 2'd0;
                rtTuse = 2'd0;
            end
            opJ: isJ = 1'b1;
            default: ;
        endcase
    end

    // Operands as seen by the branch compare and the execute stage
    assign rsVal = (fwdRsD == fwdM) ? resultM : (fwdRsD == fwdW) ? resultW : rsData;
    assign rtVal = (fwdRtD == fwdM) ? resultM : (fwdRtD == fwdW) ? resultW : rtData;

    assign pcPlus4 = pcD + 32'd4;
    assign branchTaken = isJ || (isBeq && rsVal == rtVal);
    assign branchTarget = isJ ? {pcPlus4[31:28], instD[25:0], 2'b00}
                              : pcPlus4 + {immSign[29:0], 2'b00};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            destE <= '0;
            tnewE <= 2'd0;
            isLoadE <= 1'b0;
            isStoreE <= 1'b0;
        end else begin
            // Bubble into execute while the load result is pending
            destE <= stall ? '0 : dest;
            tnewE <= stall ? 2'd0 : tnew;
            isLoadE <= !stall && isLoad;
            isStoreE <= !stall && isStore;
        end
    end

    always_ff @(posedge clk) begin
        aluOpE <= aluOp;
        useImmE <= useImm;
        immE <= imm;
        rsValE <= rsVal;
        rtValE <= rtVal;
        pcE <= pcD;
    end

endmodule

// File: execute/executeStage.sv
`timescale 1ns/1ps
module executeStage import mipsPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  mipsPkg::aluOpE      aluOpE,
    input  logic                useImmE,
    input  logic [dataW-1:0]    immE,
    input  logic [dataW-1:0]    rsValE,
    input  logic [dataW-1:0]    rtValE,
    input  logic [regAddrW-1:0] destE,
    input  stageTimeT           tnewE,
    input  logic                isLoadE,
    input  logic                isStoreE,
    input  logic [dataW-1:0]    pcE,
    input  fwdSelE              fwdRsE,
    input  fwdSelE              fwdRtE,
    input  logic [dataW-1:0]    resultW,
    output logic [dataW-1:0]    resultM,
    output logic [dataW-1:0]    storeDataM,
    output logic [regAddrW-1:0] destM,
    output stageTimeT           tnewM,
    output logic                isLoadM,
    output logic                isStoreM,
    output logic [dataW-1:0]    pcM
);

    fwdSelE           rsSel, rtSel;
    logic [dataW-1:0] opA, opB, srcB, aluOut;

    // Selects are worked out while the instruction sits in decode
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rsSel <= fwdNone;
            rtSel <= fwdNone;
        end else begin
            rsSel <= fwdRsE;
            rtSel <= fwdRtE;
        end
    end

    assign opA = (rsSel == fwdM) ? resultM : (rsSel == fwdW) ? resultW : rsValE;
    assign opB = (rtSel == fwdM) ? resultM : (rtSel == fwdW) ? resultW : rtValE;
    assign srcB = useImmE ? immE : opB;

    always_comb begin
        case (aluOpE)
            aluSub:  aluOut = opA - srcB;
            aluOr:   aluOut = opA | srcB;
            aluLui:  aluOut = {srcB[15:0], 16'b0};
            default: aluOut = opA + srcB;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            destM <= '0;
            tnewM <= 2'd0;
            isLoadM <= 1'b0;
            isStoreM <= 1'b0;
        end else begin
            destM <= destE;
            // One stage closer to ready, floor at zero
            tnewM <= (tnewE != 2'd0) ? tnewE - 2'd1 : 2'd0;
            isLoadM <= isLoadE;
            isStoreM <= isStoreE;
        end
    end

    always_ff @(posedge clk) begin
        resultM <= aluOut;
        storeDataM <= opB;
        pcM <= pcE;
    end

endmodule

// File: memory/memoryStage.sv
`timescale 1ns/1ps
module memoryStage import mipsPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [dataW-1:0]    resultM,
    input  logic [dataW-1:0]    storeDataM,
    input  logic [regAddrW-1:0] destM,
    input  logic                isLoadM,
    input  logic                isStoreM,
    input  logic [dataW-1:0]    pcM,
    output logic [dataW-1:0]    dataAddr,
    output logic [dataW-1:0]    dataWdata,
    output logic [3:0]          dataByteen,
    input  logic [dataW-1:0]    dataRdata,
    output logic [dataW-1:0]    macroscopicPc,
    output logic [dataW-1:0]    resultW,
    output logic                grfWe,
    output logic [regAddrW-1:0] grfAddr,
    output logic [dataW-1:0]    grfWdata,
    output logic [dataW-1:0]    grfInstAddr
);

    logic [dataW-1:0] wbValue;

    // Word-only data port
    assign dataAddr = resultM;
    assign dataWdata = storeDataM;
    assign dataByteen = isStoreM ? 4'b1111 : 4'b0000;
    assign macroscopicPc = pcM;

    assign wbValue = isLoadM ? dataRdata : resultM;
    assign resultW = grfWdata;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            grfWe <= 1'b0;
            grfAddr <= '0;
        end else begin
            grfWe <= destM != '0;
            grfAddr <= destM;
        end
    end

    always_ff @(posedge clk) begin
        grfWdata <= wbValue;
        grfInstAddr <= pcM;
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps
module regFile import mipsPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rsAddr,
    input  logic [regAddrW-1:0] rtAddr,
    output logic [dataW-1:0]    rsData,
    output logic [dataW-1:0]    rtData,
    input  logic                we,
    input  logic [regAddrW-1:0] wAddr,
    input  logic [dataW-1:0]    wData
);

    logic [dataW-1:0] regs [2**regAddrW];

    // Entry zero is never written so it reads as zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // Same-cycle write passes straight to the read port
    assign rsData = (we && rsAddr != '0 && rsAddr == wAddr) ? wData : regs[rsAddr];
    assign rtData = (we && rtAddr != '0 && rtAddr == wAddr) ? wData : regs[rtAddr];

endmodule

// File: src/hazardUnit.sv
`timescale 1ns/1ps
module hazardUnit import mipsPkg::*; (
    input  logic [regAddrW-1:0] rsAddr,
    input  logic [regAddrW-1:0] rtAddr,
    input  stageTimeT           rsTuse,
    input  stageTimeT           rtTuse,
    input  logic [regAddrW-1:0] destE,
    input  stageTimeT           tnewE,
    input  logic [regAddrW-1:0] destM,
    input  stageTimeT           tnewM,
    input  logic [regAddrW-1:0] grfAddr,
    input  logic                grfWe,
    output logic                stall,
    output fwdSelE              fwdRsD,
    output fwdSelE              fwdRtD,
    output fwdSelE              fwdRsE,
    output fwdSelE              fwdRtE
);

    // Producer result not ready by the time the source is used
    function automatic logic mustWait(logic [regAddrW-1:0] src, stageTimeT tuse);
        return src != '0 && ((src == destE && tnewE > tuse) ||
                             (src == destM && tnewM > tuse));
    endfunction

    // Decode picks a ready memory result, else the retiring one
    function automatic fwdSelE pickDecode(logic [regAddrW-1:0] src);
        if (src != '0 && src == destM && tnewM == 2'd0) begin
            return fwdM;
        end
        if (src != '0 && grfWe && src == grfAddr) begin
            return fwdW;
        end
        return fwdNone;
    endfunction

    // For execute next cycle, what is in E now will sit in M, M in W
    function automatic fwdSelE pickExecute(logic [regAddrW-1:0] src);
        if (src != '0 && src == destE) begin
            return fwdM;
        end
        if (src != '0 && src == destM && tnewM != 2'd0) begin
            return fwdW;
        end
        return fwdNone;
    endfunction

    always_comb begin
        stall = mustWait(rsAddr, rsTuse) || mustWait(rtAddr, rtTuse);
        fwdRsD = pickDecode(rsAddr);
        fwdRtD = pickDecode(rtAddr);
        fwdRsE = pickExecute(rsAddr);
        fwdRtE = pickExecute(rtAddr);
    end

endmodule

// File: src/cpuTop.sv
`timescale 1ns/1ps
module cpuTop import mipsPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    output logic [dataW-1:0]    instAddr,
    input  logic [dataW-1:0]    instData,
    output logic [dataW-1:0]    dataAddr,
    output logic [dataW-1:0]    dataWdata,
    output logic [3:0]          dataByteen,
    input  logic [dataW-1:0]    dataRdata,
    output logic                grfWe,
    output logic [regAddrW-1:0] grfAddr,
    output logic [dataW-1:0]    grfWdata,
    output logic [dataW-1:0]    grfInstAddr,
    output logic [dataW-1:0]    macroscopicPc
);

    // Fetch to decode
    logic [dataW-1:0]    instD, pcD;
    logic                branchTaken;
    logic [dataW-1:0]    branchTarget;

    // Register file and hazard signals
    logic [regAddrW-1:0] rsAddr, rtAddr;
    logic [dataW-1:0]    rsData, rtData;
    stageTimeT           rsTuse, rtTuse;
    logic                stall;
    fwdSelE              fwdRsD, fwdRtD, fwdRsE, fwdRtE;

    // Decode to execute
    mipsPkg::aluOpE      aluOpE;
    logic                useImmE;
    logic [dataW-1:0]    immE, rsValE, rtValE, pcE;
    logic [regAddrW-1:0] destE;
    stageTimeT           tnewE;
    logic                isLoadE, isStoreE;

    // Execute to memory, memory to writeback
    logic [dataW-1:0]    resultM, storeDataM, pcM, resultW;
    logic [regAddrW-1:0] destM;
    stageTimeT           tnewM;
    logic                isLoadM, isStoreM;

    fetchStage #(.ResetPc(resetPc)) u_fetch (
        .clk, .arstN, .stall, .branchTaken, .branchTarget,
        .instAddr, .instData, .instD, .pcD
    );

    decodeStage u_decode (
        .clk, .arstN, .instD, .pcD, .rsData, .rtData, .rsAddr, .rtAddr,
        .rsTuse, .rtTuse, .fwdRsD, .fwdRtD, .resultM, .resultW, .stall,
        .branchTaken, .branchTarget, .aluOpE, .useImmE, .immE, .rsValE,
        .rtValE, .destE, .tnewE, .isLoadE, .isStoreE, .pcE
    );

    regFile u_regFile (
        .clk, .arstN, .rsAddr, .rtAddr, .rsData, .rtData,
        .we(grfWe), .wAddr(grfAddr), .wData(grfWdata)
    );

    executeStage u_execute (
        .clk, .arstN, .aluOpE, .useImmE, .immE, .rsValE, .rtValE, .destE,
        .tnewE, .isLoadE, .isStoreE, .pcE, .fwdRsE, .fwdRtE, .resultW,
        .resultM, .storeDataM, .destM, .tnewM, .isLoadM, .isStoreM, .pcM
    );

    memoryStage u_memory (
        .clk, .arstN, .resultM, .storeDataM, .destM, .isLoadM, .isStoreM,
        .pcM, .dataAddr, .dataWdata, .dataByteen, .dataRdata, .macroscopicPc,
        .resultW, .grfWe, .grfAddr, .grfWdata, .grfInstAddr
    );

    hazardUnit u_hazard (
        .rsAddr, .rtAddr, .rsTuse, .rtTuse, .destE, .tnewE, .destM, .tnewM,
        .grfAddr, .grfWe, .stall, .fwdRsD, .fwdRtD, .fwdRsE, .fwdRtE
    );

endmodule

// File: test/cpuTb_chk.sv
`timescale 1ns/1ps
module cpuTb_chk (
    input logic        clk,
    input logic        arstN,
    input logic [31:0] instAddr,
    input logic [3:0]  dataByteen,
    input logic        grfWe,
    input logic [4:0]  grfAddr
);

    // r0 never shows up on the trace port
    property noZeroWrite;
        @(posedge clk) disable iff (!arstN) grfWe |-> grfAddr != 5'd0;
    endproperty

    // Word stores only
    property wordByteen;
        @(posedge clk) disable iff (!arstN) dataByteen == 4'b0000 || dataByteen == 4'b1111;
    endproperty

    property alignedFetch;
        @(posedge clk) disable iff (!arstN) instAddr[1:0] == 2'b00;
    endproperty

    aNoZeroWrite: assert property (noZeroWrite)
        else $error("register zero written on the trace port");
    aWordByteen: assert property (wordByteen)
        else $error("byte enable is neither zero nor all ones");
    aAlignedFetch: assert property (alignedFetch)
        else $error("fetch address is not word aligned");

endmodule

// File: test/cpuTb.sv
`timescale 1ns/1ps
module cpuTb;

    localparam int timeoutCycles = 50;
    localparam int drainCycles = 20;
    localparam logic [31:0] progBase = 32'h0000_3000;

    // MIPS encodings used by the program
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;

    logic        clk = 1'b0;
    logic        arstN;
    logic [31:0] instAddr, instData, dataAddr, dataWdata, dataRdata;
    logic [3:0]  dataByteen;
    logic        grfWe;
    logic [4:0]  grfAddr;
    logic [31:0] grfWdata, grfInstAddr, macroscopicPc;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    string       expName [$];
    logic [71:0] expTrace [$];
    int          passCount;
    int          failCount;

    cpuTop u_dut (
        .clk, .arstN, .instAddr, .instData, .dataAddr, .dataWdata, .dataByteen,
        .dataRdata, .grfWe, .grfAddr, .grfWdata, .grfInstAddr, .macroscopicPc
    );

    bind cpuTop cpuTb_chk u_chk (
        .clk, .arstN, .instAddr, .dataByteen, .grfWe, .grfAddr
    );

    always #5 clk = ~clk;

    // Both memories answer in the same cycle
    assign instData = imem[instAddr[9:2]];
    assign dataRdata = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataByteen == 4'hf) begin
            dmem[dataAddr[7:2]] <= dataWdata;
        end
    end

    function automatic logic [31:0] rType(int rs, int rt, int rd, logic [5:0] fn);
        return {opSpecial, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jType(logic [31:0] target);
        return {opJ, target[27:2]};
    endfunction

    // Contents of a data word nobody stored to
    function automatic logic [31:0] fillWord(logic [31:0] addr);
        return ~addr ^ {addr[15:0], addr[31:16]};
    endfunction

    task automatic loadProgram();
        logic [31:0] prog [$];
        // ALU chain, each result used right away
        prog.push_back(iType(opOri, 0, 1, 'h1234));
        prog.push_back(iType(opLui, 0, 2, 'habcd));
        prog.push_back(rType(1, 2, 3, fnAddu));
        prog.push_back(rType(3, 1, 4, fnSubu));
        prog.push_back(rType(1, 3, 5, fnSubu));
        // Write to r0 is dropped, then r0 is read
        prog.push_back(iType(opOri, 0, 0, 'h00ff));
        prog.push_back(rType(0, 5, 6, fnAddu));
        // Store, load back, load-use
        prog.push_back(iType(opOri, 0, 7, 'h0010));
        prog.push_back(iType(opSw, 7, 3, 4));
        prog.push_back(iType(opLw, 7, 8, 4));
        prog.push_back(rType(8, 1, 9, fnAddu));
        // Taken beq to 3038, slot at 3030, 3034 skipped
        prog.push_back(iType(opBeq, 3, 8, 2));
        prog.push_back(iType(opOri, 0, 11, 'h0011));
        prog.push_back(iType(opOri, 0, 12, 'hdead));
        prog.push_back(iType(opBeq, 1, 2, 2));
        prog.push_back(iType(opOri, 0, 13, 'h0013));
        prog.push_back(iType(opOri, 0, 14, 'h0014));
        // Jump over 304c
        prog.push_back(jType(32'h0000_3050));
        prog.push_back(rType(13, 14, 15, fnAddu));
        prog.push_back(iType(opOri, 0, 16, 'hbeef));
        prog.push_back(iType(opLw, 0, 17, 'h0020));
        prog.push_back(rType(17, 9, 18, fnSubu));
        prog.push_back(iType(opSw, 7, 18, 0));
        // Beyond the program only writes to r0
        for (int i = 0; i < 256; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = iType(opOri, 0, 0, int'(progBase) + 4 * i);
            end
        end
    endtask

    task automatic loadData();
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= fillWord(32'(i * 4));
        end
    endtask

    task automatic addTrace(string name, logic [31:0] pc, int rd, logic [31:0] value);
        expName.push_back(name);
        expTrace.push_back({pc, 3'd0, rd[4:0], value});
    endtask

    task automatic loadTrace();
        addTrace("ori r1", 32'h3000, 1, 32'h0000_1234);
        addTrace("lui r2", 32'h3004, 2, 32'habcd_0000);
        addTrace("addu forward r3", 32'h3008, 3, 32'h0000_1234 + 32'habcd_0000);
        addTrace("subu forward r4", 32'h300c, 4, 32'habcd_1234 - 32'h0000_1234);
        addTrace("subu forward r5", 32'h3010, 5, 32'h0000_1234 - 32'habcd_1234);
        addTrace("addu with r0 r6", 32'h3018, 6, 32'h0000_1234 - 32'habcd_1234);
        addTrace("ori base r7", 32'h301c, 7, 32'h0000_0010);
        addTrace("load after store r8", 32'h3024, 8, 32'habcd_1234);
        addTrace("load-use addu r9", 32'h3028, 9, 32'habcd_1234 + 32'h0000_1234);
        addTrace("beq taken slot r11", 32'h3030, 11, 32'h0000_0011);
        addTrace("beq not taken slot r13", 32'h303c, 13, 32'h0000_0013);
        addTrace("beq fall-through r14", 32'h3040, 14, 32'h0000_0014);
        addTrace("j delay slot r15", 32'h3048, 15, 32'h0000_0013 + 32'h0000_0014);
        addTrace("load fill word r17", 32'h3050, 17, fillWord(32'h20));
        addTrace("load-use subu r18", 32'h3054, 18, fillWord(32'h20) - 32'habcd_2468);
    endtask

    task automatic checkValue(string name, logic [71:0] expected, logic [71:0] actual);
        if (actual === expected) begin
            passCount++;
            $display("Pass %s", name);
        end else begin
            failCount++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Next trace pulse on the falling edge and the memory-stage PC one cycle before it
    task automatic waitWrite(output bit seen, output logic [31:0] memPc);
        seen = 1'b0;
        memPc = '0;
        for (int n = 0; n < timeoutCycles && !seen; n++) begin
            memPc = macroscopicPc;
            @(negedge clk);
            seen = grfWe;
        end
    endtask

    initial begin
        bit seen;
        bit timedOut;
        int extraWrites;
        logic [31:0] memPc;
        logic [71:0] entry;
        arstN <= 1'b0;
        passCount = 0;
        failCount = 0;
        timedOut = 1'b0;
        extraWrites = 0;
        loadProgram();
        loadData();
        loadTrace();
        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        for (int k = 0; k < expTrace.size() && !timedOut; k++) begin
            entry = expTrace[k];
            waitWrite(seen, memPc);
            if (seen) begin
                checkValue(expName[k], entry, {grfInstAddr, 3'd0, grfAddr, grfWdata});
                checkValue({expName[k], " memory pc"}, {40'd0, entry[71:40]},
                           {40'd0, memPc});
            end else begin
                failCount++;
                timedOut = 1'b1;
                $display("Timeout: no register write seen for %s", expName[k]);
            end
        end

        if (!timedOut) begin
            // Only r0 writes remain once the program has drained
            for (int n = 0; n < drainCycles; n++) begin
                @(negedge clk);
                if (grfWe) begin
                    extraWrites++;
                end
            end
            checkValue("no extra writes", 72'd0, 72'(extraWrites));
            checkValue("stored word at 0x14", {40'd0, 32'habcd_1234}, {40'd0, dmem[5]});
            checkValue("stored word at 0x10", {40'd0, fillWord(32'h20) - 32'habcd_2468},
                       {40'd0, dmem[4]});
        end

        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
common/mipsPkg.sv
fetch/fetchStage.sv
decode/decodeStage.sv
execute/executeStage.sv
memory/memoryStage.sv
src/regFile.sv
src/hazardUnit.sv
src/cpuTop.sv
test/cpuTb_chk.sv
test/cpuTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = cpuTb
FLIST     = flist.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
